// ==== Makefile ====
# Verilator build and run of the trace controller testbench

TOP = tb_tcm

all: run

build:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@! grep -q "test failed" sim.log
	@grep -q "test passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module tcm

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== dbg_conf_regs.sv ====
/*
 * Register stage of the trace controller.
 * Turns writes to the system control register into one-cycle pulses,
 * answers register reads one cycle after the command, and asks the
 * performance counters for a snapshot.
 */
`timescale 1ns/1ps
`default_nettype none

module dbg_conf_regs (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             wr_en,
   input  logic                             rd_en,
   input  dbg_pkg::reg_addr_t               addr,
   input  logic [dbg_pkg::flit_data_w-1:0]  wdata,
   input  logic [dbg_pkg::src_w-1:0]        rd_src,
   output logic                             cpu_stall,
   output logic                             cpu_reset,
   output logic                             start_cpu,
   output logic                             snapshot,
   input  logic [dbg_pkg::perf_cnt_w-1:0]   halt_snap,
   input  logic [dbg_pkg::perf_cnt_w-1:0]   cycle_snap,
   output logic                             rsp_valid,
   output logic [dbg_pkg::dest_w-1:0]       rsp_dest,
   output logic [dbg_pkg::flit_data_w-1:0]  rsp_data
);

   localparam int hw = dbg_pkg::flit_data_w; // one register word

   logic          ctrl_wr;
   logic [hw-1:0] rd_word;

   // only the control register takes writes
   assign ctrl_wr = wr_en && (addr == dbg_pkg::reg_sys_ctrl);

   // pulses last one cycle, nothing is stored
   always_ff @(posedge clk) begin
      if (rst) begin
         cpu_stall <= 1'b0;
         cpu_reset <= 1'b0;
         start_cpu <= 1'b0;
         snapshot  <= 1'b0;
      end else begin
         cpu_stall <= ctrl_wr & wdata[dbg_pkg::ctrl_stall_bit];
         cpu_reset <= ctrl_wr & wdata[dbg_pkg::ctrl_reset_bit];
         start_cpu <= ctrl_wr & wdata[dbg_pkg::ctrl_start_bit];
         snapshot  <= ctrl_wr & wdata[dbg_pkg::ctrl_snapshot_bit]; // to counters
      end
   end

   // read mux
   always_comb begin
      case (addr)
         dbg_pkg::reg_version:      rd_word = dbg_pkg::version_word;
         dbg_pkg::reg_system_id:    rd_word = dbg_pkg::system_id;
         dbg_pkg::reg_module_count: rd_word = dbg_pkg::module_count;
         dbg_pkg::reg_sys_ctrl:     rd_word = '0; // pulses only, reads as zero
         dbg_pkg::reg_halt_hi:      rd_word = halt_snap[dbg_pkg::perf_cnt_w-1 -: hw];
         dbg_pkg::reg_halt_lo:      rd_word = halt_snap[hw-1:0];
         dbg_pkg::reg_cycle_hi:     rd_word = cycle_snap[dbg_pkg::perf_cnt_w-1 -: hw];
         dbg_pkg::reg_cycle_lo:     rd_word = cycle_snap[hw-1:0];
         default:                   rd_word = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst)
         rsp_valid <= 1'b0;
      else
         rsp_valid <= rd_en; // response one cycle after the command
   end

   // response payload
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rsp_dest <= rd_src[dbg_pkg::dest_w-1:0]; // requester becomes dest
         rsp_data <= rd_word;
      end
   end

endmodule

`default_nettype wire

// ==== dbg_perf_counters.sv ====
/*
 * Debug performance counters.
 * Counts halted system cycles and all cycles, saturating together.
 * A snapshot pulse copies both counts out and restarts them from zero.
 */
`timescale 1ns/1ps
`default_nettype none

module dbg_perf_counters (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           sys_clk_is_halted,
   input  logic                           snapshot,
   output logic [dbg_pkg::perf_cnt_w-1:0] halt_snap,
   output logic [dbg_pkg::perf_cnt_w-1:0] cycle_snap
);

   logic [dbg_pkg::perf_cnt_w-1:0] halt_cnt;  // cycles with sys clock halted
   logic [dbg_pkg::perf_cnt_w-1:0] cycle_cnt; // every cycle
   logic                           sat;

   // either one full freezes both, keeps the ratio meaningful
   assign sat = (&halt_cnt) | (&cycle_cnt);

   always_ff @(posedge clk) begin
      if (rst) begin
         halt_cnt   <= '0;
         cycle_cnt  <= '0;
         halt_snap  <= '0; // reads zero until first snapshot
         cycle_snap <= '0;
      end else if (snapshot) begin
         halt_snap  <= halt_cnt;
         cycle_snap <= cycle_cnt;
         halt_cnt   <= '0;
         cycle_cnt  <= '0;
      end else if (!sat) begin
         cycle_cnt <= cycle_cnt + 1'b1;
         if (sys_clk_is_halted)
            halt_cnt <= halt_cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== dbg_pkg.sv ====
/*
 * Shared constants for the debug NoC trace controller.
 * Flit layout, header fields, packet classes, register map and identity words.
 * All design files refer to these through dbg_pkg:: scoped names.
 */
`default_nettype none

package dbg_pkg;

   // flit layout, type field sits above the payload
   localparam int flit_data_w = 16;
   localparam int flit_type_w = 2;
   localparam int flit_w      = flit_type_w + flit_data_w;

   typedef logic [flit_w-1:0] flit_t;

   // flit type codes
   localparam logic [flit_type_w-1:0] ftype_payload = 2'b00; // middle flit
   localparam logic [flit_type_w-1:0] ftype_header  = 2'b01; // first flit
   localparam logic [flit_type_w-1:0] ftype_last    = 2'b10; // final flit
   localparam logic [flit_type_w-1:0] ftype_single  = 2'b11; // whole packet in one flit

   // header flit fields
   localparam int dest_w        = 5;
   localparam int class_w       = 3;
   localparam int src_w         = 8;
   localparam int hdr_dest_lsb  = 11; // dest in bits 15..11
   localparam int hdr_class_lsb = 8;  // class in bits 10..8

   // packet classes
   localparam logic [class_w-1:0] class_read_req  = 3'd0;
   localparam logic [class_w-1:0] class_write_req = 3'd1;
   localparam logic [class_w-1:0] class_read_resp = 3'd2;

   // this endpoint on the debug network
   localparam logic [dest_w-1:0] tcm_node_addr = 5'd1;

   // register bank
   localparam int conf_regs = 8;
   typedef logic [$clog2(conf_regs)-1:0] reg_addr_t;

   localparam reg_addr_t reg_version      = 3'd0;
   localparam reg_addr_t reg_system_id    = 3'd1;
   localparam reg_addr_t reg_module_count = 3'd2;
   localparam reg_addr_t reg_sys_ctrl     = 3'd3;
   localparam reg_addr_t reg_halt_hi      = 3'd4; // halted cycles, upper word
   localparam reg_addr_t reg_halt_lo      = 3'd5;
   localparam reg_addr_t reg_cycle_hi     = 3'd6; // all cycles, upper word
   localparam reg_addr_t reg_cycle_lo     = 3'd7;

   // system control register bits, each one a single-cycle pulse
   localparam int ctrl_stall_bit    = 0;
   localparam int ctrl_reset_bit    = 2;
   localparam int ctrl_snapshot_bit = 3;
   localparam int ctrl_start_bit    = 4;

   // identity words, read only
   localparam logic [flit_data_w-1:0] version_word = 16'd0;
   localparam logic [flit_data_w-1:0] system_id    = 16'h5a17;
   localparam logic [flit_data_w-1:0] module_count = 16'd3; // other debug modules

   // performance counters
   localparam int perf_cnt_w = 32;

endpackage

`default_nettype wire

// ==== dbgnoc_rx.sv ====
/*
 * Receive stage of the trace controller.
 * Accepts request flits, checks destination, class and packet length,
 * and turns each well-formed read or write into a one-cycle command.
 * Everything else is swallowed up to its last flit.
 */
`timescale 1ns/1ps
`default_nettype none

module dbgnoc_rx (
   input  logic                            clk,
   input  logic                            rst,
   input  dbg_pkg::flit_t                  in_flit,
   input  logic                            in_valid,
   output logic                            in_ready,
   input  logic                            tx_busy,
   output logic                            wr_en,
   output logic                            rd_en,
   output dbg_pkg::reg_addr_t              addr,
   output logic [dbg_pkg::flit_data_w-1:0] wdata,
   output logic [dbg_pkg::src_w-1:0]       rd_src
);

   typedef enum logic [1:0] {st_idle, st_addr, st_data, st_discard} state_t;

   state_t                            state;
   logic                              is_write; // kind of request in flight
   logic                              xfer;
   logic [dbg_pkg::flit_type_w-1:0]   ftype;
   logic [dbg_pkg::dest_w-1:0]        hdr_dest;
   logic [dbg_pkg::class_w-1:0]       hdr_class;
   logic                              hdr_ok;

   // one response at a time, block while tx works and right after a read
   assign in_ready = ~tx_busy & ~rd_en;
   assign xfer     = in_valid & in_ready;

   assign ftype     = in_flit[dbg_pkg::flit_w-1 -: dbg_pkg::flit_type_w];
   assign hdr_dest  = in_flit[dbg_pkg::hdr_dest_lsb +: dbg_pkg::dest_w];
   assign hdr_class = in_flit[dbg_pkg::hdr_class_lsb +: dbg_pkg::class_w];
   assign hdr_ok    = (hdr_dest == dbg_pkg::tcm_node_addr) &&
                      ((hdr_class == dbg_pkg::class_read_req) ||
                       (hdr_class == dbg_pkg::class_write_req));

   always_ff @(posedge clk) begin
      rd_en <= 1'b0; // command pulses
      wr_en <= 1'b0;
      if (rst) begin
         state    <= st_idle;
         is_write <= 1'b0;
      end else if (xfer) begin
         case (state)
            st_idle: begin
               if (ftype == dbg_pkg::ftype_header) begin
                  state    <= hdr_ok ? st_addr : st_discard;
                  is_write <= (hdr_class == dbg_pkg::class_write_req);
               end else if (ftype == dbg_pkg::ftype_payload) begin
                  state <= st_discard; // stray body, drop to its end
               end
               // single and stray last flits are simply eaten
            end
            st_addr: begin
               if (ftype == dbg_pkg::ftype_last) begin
                  state <= st_idle;
                  rd_en <= ~is_write; // a write ending here is too short
               end else if (is_write && ftype == dbg_pkg::ftype_payload) begin
                  state <= st_data;
               end else begin
                  state <= st_discard; // read too long or bad flit
               end
            end
            st_data: begin
               if (ftype == dbg_pkg::ftype_last) begin
                  state <= st_idle;
                  wr_en <= 1'b1;
               end else begin
                  state <= st_discard; // write too long
               end
            end
            st_discard: begin
               if (ftype == dbg_pkg::ftype_last)
                  state <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   // captured fields, only meaningful alongside a command
   always_ff @(posedge clk) begin
      if (xfer) begin
         if (state == st_idle && ftype == dbg_pkg::ftype_header)
            rd_src <= in_flit[dbg_pkg::src_w-1:0]; // requester id
         if (state == st_addr)
            addr <= in_flit[$bits(dbg_pkg::reg_addr_t)-1:0];
         if (state == st_data)
            wdata <= in_flit[dbg_pkg::flit_data_w-1:0];
      end
   end

endmodule

`default_nettype wire

// ==== dbgnoc_tx.sv ====
/*
 * Response packetizer of the trace controller.
 * Sends one read result as a header flit plus a last flit,
 * holding each flit until the network takes it.
 * tx_busy tells the receiver to hold off new requests meanwhile.
 */
`timescale 1ns/1ps
`default_nettype none

module dbgnoc_tx (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            rsp_valid,
   input  logic [dbg_pkg::dest_w-1:0]      rsp_dest,
   input  logic [dbg_pkg::flit_data_w-1:0] rsp_data,
   output dbg_pkg::flit_t                  out_flit,
   output logic                            out_valid,
   input  logic                            out_ready,
   output logic                            tx_busy
);

   typedef enum logic [1:0] {st_idle, st_header, st_last} state_t;

   // own source id, node address zero-extended
   localparam logic [dbg_pkg::src_w-1:0] src_id =
      {{(dbg_pkg::src_w - dbg_pkg::dest_w){1'b0}}, dbg_pkg::tcm_node_addr};

   state_t                            state;
   logic [dbg_pkg::dest_w-1:0]        dest_q;
   logic [dbg_pkg::flit_data_w-1:0]   data_q;
   logic                              xfer;

   assign out_valid = (state != st_idle);
   assign xfer      = out_valid & out_ready;
   assign tx_busy   = rsp_valid | (state != st_idle); // busy from rsp_valid on

   // flit built from held registers, stable under back-pressure
   always_comb begin
      if (state == st_header)
         out_flit = {dbg_pkg::ftype_header, dest_q, dbg_pkg::class_read_resp, src_id};
      else
         out_flit = {dbg_pkg::ftype_last, data_q};
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle:   if (rsp_valid) state <= st_header;
            st_header: if (xfer) state <= st_last;
            st_last:   if (xfer) state <= st_idle; // response done
            default:   state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == st_idle && rsp_valid) begin
         dest_q <= rsp_dest;
         data_q <= rsp_data;
      end
   end

endmodule

`default_nettype wire

// ==== tb_tcm.sv ====
/*
 * Testbench for the trace controller.
 * Seeded random requests over the debug NoC, checked against a model of the
 * register map and both performance counters. Response flits, in_ready and
 * CPU pulses are compared every cycle, and a cycle limit stops a stuck run.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_tcm;

   logic                           clk, rst, sys_clk_is_halted;
   dbg_pkg::flit_t                 in_flit, out_flit;
   logic                           in_valid, in_ready, out_valid, out_ready;
   logic                           cpu_stall, cpu_reset, start_cpu;

   dbg_pkg::flit_t                 pkt_q[$];  // flits still to send
   dbg_pkg::flit_t                 exp_q[$];  // expected response flits, in order
   dbg_pkg::flit_t                 exp_f;     // expected flit being compared
   logic                           last_ctrl; // last flit of a control write on the bus
   logic                           rd_req;    // a well-formed read is on the bus
   logic                           rd_pend;   // read issued, response not yet out
   logic [dbg_pkg::flit_data_w-1:0] ctrl_bits, pend_bits;
   int                             ctrl_cd;   // edges left until the pulse edge has passed
   int                             ready_pct, halt_pct;
   int                             errors = 0;
   int                             checks = 0;
   int                             test_no, err_start, cycles;
   logic [dbg_pkg::perf_cnt_w-1:0] m_halt, m_cycle, m_halt_snap, m_cycle_snap;

   tcm dut_i (
      .clk(clk), .rst(rst), .sys_clk_is_halted(sys_clk_is_halted),
      .in_flit(in_flit), .in_valid(in_valid), .in_ready(in_ready),
      .out_flit(out_flit), .out_valid(out_valid), .out_ready(out_ready),
      .cpu_stall(cpu_stall), .cpu_reset(cpu_reset), .start_cpu(start_cpu));

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // random back-pressure and halt pattern, changed just after each edge
   initial begin
      out_ready         = 1'b0;
      sys_clk_is_halted = 1'b0;
      forever begin
         @(posedge clk);
         #2;
         out_ready         = ($urandom_range(99, 0) < ready_pct);
         sys_clk_is_halted = ($urandom_range(99, 0) < halt_pct);
      end
   end

   // limit is about twice the summed test length
   initial begin
      cycles = 0;
      while (cycles < 4000) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: the run did not finish within %0d cycles", cycles);
      $display("test failed");
      $finish;
   end

   task automatic compare_flit(input dbg_pkg::flit_t got, input dbg_pkg::flit_t exp,
                               input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %0t: %s flit %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic compare_pulse(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   function automatic dbg_pkg::flit_t make_header(input logic [4:0] dest,
                                                  input logic [2:0] cls,
                                                  input logic [7:0] src);
      return {dbg_pkg::ftype_header, dest, cls, src};
   endfunction

   // register map as the host should see it
   function automatic logic [15:0] model_read(input dbg_pkg::reg_addr_t a);
      case (a)
         dbg_pkg::reg_version:      return dbg_pkg::version_word;
         dbg_pkg::reg_system_id:    return dbg_pkg::system_id;
         dbg_pkg::reg_module_count: return dbg_pkg::module_count;
         dbg_pkg::reg_halt_hi:      return m_halt_snap[31:16];
         dbg_pkg::reg_halt_lo:      return m_halt_snap[15:0];
         dbg_pkg::reg_cycle_hi:     return m_cycle_snap[31:16];
         dbg_pkg::reg_cycle_lo:     return m_cycle_snap[15:0];
         default:                   return 16'h0000; // control word reads zero
      endcase
   endfunction

   // model and monitors, each negedge predicts the coming rising edge
   always @(negedge clk) begin
      if (rst !== 1'b0) begin
         m_halt       = '0;
         m_cycle      = '0;
         m_halt_snap  = '0;
         m_cycle_snap = '0;
         ctrl_cd      = 0;
         rd_pend      = 1'b0;
      end else begin
         // low from the read command until its last response flit goes out
         compare_pulse(in_ready, !rd_pend, "in_ready");
         compare_pulse(cpu_stall, (ctrl_cd == 1) && pend_bits[dbg_pkg::ctrl_stall_bit],
                       "cpu_stall");
         compare_pulse(cpu_reset, (ctrl_cd == 1) && pend_bits[dbg_pkg::ctrl_reset_bit],
                       "cpu_reset");
         compare_pulse(start_cpu, (ctrl_cd == 1) && pend_bits[dbg_pkg::ctrl_start_bit],
                       "start_cpu");
         if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("ERROR %0t: response flit %h with no read outstanding",
                        $time, out_flit);
            end else begin
               exp_f = exp_q.pop_front();
               compare_flit(out_flit, exp_f, "response");
               if (exp_f[dbg_pkg::flit_w-1 -: dbg_pkg::flit_type_w] == dbg_pkg::ftype_last)
                  rd_pend = 1'b0; // receiver free again after this edge
            end
         end
         if (ctrl_cd == 1 && pend_bits[dbg_pkg::ctrl_snapshot_bit]) begin
            m_halt_snap  = m_halt;      // latch and restart
            m_cycle_snap = m_cycle;
            m_halt       = '0;
            m_cycle      = '0;
         end else if (!(&m_halt) && !(&m_cycle)) begin
            m_cycle = m_cycle + 1'b1;   // both freeze once either is full
            if (sys_clk_is_halted)
               m_halt = m_halt + 1'b1;
         end
         if (ctrl_cd != 0)
            ctrl_cd = ctrl_cd - 1;
         if (in_valid && in_ready && last_ctrl) begin
            ctrl_cd   = 2;              // wr_en next cycle, pulses the one after
            pend_bits = ctrl_bits;
         end
         if (in_valid && in_ready && rd_req &&
             in_flit[dbg_pkg::flit_w-1 -: dbg_pkg::flit_type_w] == dbg_pkg::ftype_last)
            rd_pend = 1'b1;             // rd_en on the coming edge
      end
   end

   // sends pkt_q, random gap before each flit, holds a flit until taken
   task automatic send_pkt(input logic ctrl, input logic [15:0] bits);
      dbg_pkg::flit_t f;
      logic           rdy;
      while (pkt_q.size() != 0) begin
         f = pkt_q.pop_front();
         repeat ($urandom_range(1, 0)) begin
            @(posedge clk);
            #2;
         end
         in_flit   = f;
         in_valid  = 1'b1;
         last_ctrl = ctrl && (pkt_q.size() == 0);
         ctrl_bits = bits;
         do begin
            @(negedge clk);
            rdy = in_ready;
            @(posedge clk);
            #2;
         end while (!rdy);
         in_valid  = 1'b0;
         last_ctrl = 1'b0;
      end
   endtask

   task automatic write_reg(input logic [4:0] dest, input dbg_pkg::reg_addr_t a,
                            input logic [15:0] d);
      pkt_q.push_back(make_header(dest, dbg_pkg::class_write_req, 8'($urandom())));
      pkt_q.push_back({dbg_pkg::ftype_payload, 13'd0, a});
      pkt_q.push_back({dbg_pkg::ftype_last, d});
      // pulses only for a control write addressed to this node
      send_pkt(dest == dbg_pkg::tcm_node_addr && a == dbg_pkg::reg_sys_ctrl, d);
   endtask

   task automatic read_reg(input dbg_pkg::reg_addr_t a);
      logic [7:0] src;
      src = 8'($urandom());
      while (ctrl_cd != 0) begin // snapshot in flight, wait for it to land
         @(posedge clk);
         #2;
      end
      exp_q.push_back(make_header(src[4:0], dbg_pkg::class_read_resp,
                                  {3'b000, dbg_pkg::tcm_node_addr}));
      exp_q.push_back({dbg_pkg::ftype_last, model_read(a)});
      pkt_q.push_back(make_header(dbg_pkg::tcm_node_addr, dbg_pkg::class_read_req, src));
      pkt_q.push_back({dbg_pkg::ftype_last, 13'd0, a});
      rd_req = 1'b1;
      send_pkt(1'b0, 16'h0000);
      rd_req = 1'b0;
   endtask

   // waits out responses and pulses, then reports the test
   task automatic end_test(input string name);
      while (exp_q.size() != 0 || ctrl_cd != 0) begin
         @(posedge clk);
         #2;
      end
      repeat (6) begin // room for any stray response or pulse
         @(posedge clk);
         #2;
      end
      test_no++;
      $display("test %0d %s finished, %0d errors", test_no, name, errors - err_start);
      err_start = errors;
   endtask

   initial begin
      void'($urandom(38));
      rst       = 1'b1;
      in_valid  = 1'b0;
      in_flit   = '0;
      last_ctrl = 1'b0;
      rd_req    = 1'b0;
      ctrl_bits = '0;
      ready_pct = 80;
      halt_pct  = 30;
      test_no   = 0;
      err_start = 0;
      repeat (3) @(posedge clk);
      #2;
      rst = 1'b0;

      for (int i = 0; i < 3; i++)
         read_reg(dbg_pkg::reg_addr_t'(i));
      end_test("identity reads");

      for (int i = 0; i < 12; i++) begin
         write_reg(dbg_pkg::tcm_node_addr, dbg_pkg::reg_sys_ctrl, 16'($urandom()));
         read_reg(dbg_pkg::reg_sys_ctrl);
      end
      end_test("control pulses");

      for (int i = 0; i < 3; i++) begin // later rounds show the clear
         halt_pct = int'($urandom_range(100, 0));
         repeat ($urandom_range(60, 20)) @(posedge clk);
         #2;
         write_reg(dbg_pkg::tcm_node_addr, dbg_pkg::reg_sys_ctrl,
                   16'(1 << dbg_pkg::ctrl_snapshot_bit));
         for (int r = 4; r < 8; r++)
            read_reg(dbg_pkg::reg_addr_t'(r));
      end
      end_test("counter snapshot");

      ready_pct = 50;
      for (int i = 0; i < 200; i++)
         read_reg(dbg_pkg::reg_addr_t'($urandom_range(7, 0)));
      end_test("back-pressure");

      ready_pct = 80;
      pkt_q.push_back(make_header(dbg_pkg::tcm_node_addr + 5'd1, dbg_pkg::class_read_req,
                                  8'h11)); // read for another node
      pkt_q.push_back({dbg_pkg::ftype_last, 16'h0000});
      send_pkt(1'b0, 16'h0000);
      write_reg(dbg_pkg::tcm_node_addr ^ 5'h10, dbg_pkg::reg_sys_ctrl, 16'h001d);
      pkt_q.push_back(make_header(dbg_pkg::tcm_node_addr, 3'd5, 8'h22)); // unknown class
      pkt_q.push_back({dbg_pkg::ftype_last, 16'h0003});
      send_pkt(1'b0, 16'h0000);
      pkt_q.push_back(make_header(dbg_pkg::tcm_node_addr, dbg_pkg::class_read_req, 8'h33));
      pkt_q.push_back({dbg_pkg::ftype_payload, 16'h0001}); // read one flit too long
      pkt_q.push_back({dbg_pkg::ftype_last, 16'h0001});
      send_pkt(1'b0, 16'h0000);
      pkt_q.push_back(make_header(dbg_pkg::tcm_node_addr, dbg_pkg::class_write_req, 8'h44));
      pkt_q.push_back({dbg_pkg::ftype_last, 16'h0003}); // write cut short
      send_pkt(1'b0, 16'h0000);
      pkt_q.push_back({dbg_pkg::ftype_single, 16'hffff});
      send_pkt(1'b0, 16'h0000);
      for (int i = 0; i < 3; i++) begin // identity words ignore writes
         write_reg(dbg_pkg::tcm_node_addr, dbg_pkg::reg_addr_t'(i), 16'($urandom()));
         read_reg(dbg_pkg::reg_addr_t'(i));
      end
      end_test("filtering");

      $display("%0d tests, %0d checks, %0d errors", test_no, checks, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tcm.sv ====
/*
 * Trace controller top level.
 * Chains receive, register, counter and transmit stages
 * between the debug NoC ports and the CPU control pulses.
 */
`timescale 1ns/1ps
`default_nettype none

module tcm (
   input  logic           clk,
   input  logic           rst,
   input  logic           sys_clk_is_halted,
   input  dbg_pkg::flit_t in_flit,
   input  logic           in_valid,
   output logic           in_ready,
   output dbg_pkg::flit_t out_flit,
   output logic           out_valid,
   input  logic           out_ready,
   output logic           cpu_stall,
   output logic           cpu_reset,
   output logic           start_cpu
);

   logic                            wr_en, rd_en;
   dbg_pkg::reg_addr_t              addr;
   logic [dbg_pkg::flit_data_w-1:0] wdata;
   logic [dbg_pkg::src_w-1:0]       rd_src;
   logic                            rsp_valid;
   logic [dbg_pkg::dest_w-1:0]      rsp_dest;
   logic [dbg_pkg::flit_data_w-1:0] rsp_data;
   logic                            tx_busy;
   logic                            snapshot;
   logic [dbg_pkg::perf_cnt_w-1:0]  halt_snap, cycle_snap;

   dbgnoc_rx rx_i (
      .clk(clk), .rst(rst), .in_flit(in_flit), .in_valid(in_valid), .in_ready(in_ready),
      .tx_busy(tx_busy), .wr_en(wr_en), .rd_en(rd_en), .addr(addr), .wdata(wdata),
      .rd_src(rd_src));

   dbg_conf_regs regs_i (
      .clk(clk), .rst(rst), .wr_en(wr_en), .rd_en(rd_en), .addr(addr), .wdata(wdata),
      .rd_src(rd_src), .cpu_stall(cpu_stall), .cpu_reset(cpu_reset),
      .start_cpu(start_cpu), .snapshot(snapshot), .halt_snap(halt_snap),
      .cycle_snap(cycle_snap), .rsp_valid(rsp_valid), .rsp_dest(rsp_dest),
      .rsp_data(rsp_data));

   dbg_perf_counters cnt_i (
      .clk(clk), .rst(rst), .sys_clk_is_halted(sys_clk_is_halted),
      .snapshot(snapshot), .halt_snap(halt_snap), .cycle_snap(cycle_snap));

   dbgnoc_tx tx_i (
      .clk(clk), .rst(rst), .rsp_valid(rsp_valid), .rsp_dest(rsp_dest),
      .rsp_data(rsp_data), .out_flit(out_flit), .out_valid(out_valid),
      .out_ready(out_ready), .tx_busy(tx_busy));

endmodule

`default_nettype wire

// ==== tcm_sva.sv ====
/*
 * Concurrent checks bound into the trace controller top level.
 * Response flits hold under back-pressure, CPU pulses last one cycle
 * and stay low while reset is applied.
 */
`timescale 1ns/1ps
`default_nettype none

module tcm_sva (
   input logic           clk,
   input logic           rst,
   input dbg_pkg::flit_t out_flit,
   input logic           out_valid,
   input logic           out_ready,
   input logic           cpu_stall,
   input logic           cpu_reset,
   input logic           start_cpu
);

   // stalled flit stays put until taken
   a_flit_hold: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_flit))
      else $error("response flit changed while stalled");

   a_stall_once: assert property (@(posedge clk) disable iff (rst)
      cpu_stall |=> !cpu_stall) else $error("cpu_stall high two cycles in a row");
   a_reset_once: assert property (@(posedge clk) disable iff (rst)
      cpu_reset |=> !cpu_reset) else $error("cpu_reset high two cycles in a row");
   a_start_once: assert property (@(posedge clk) disable iff (rst)
      start_cpu |=> !start_cpu) else $error("start_cpu high two cycles in a row");

   a_quiet_in_rst: assert property (@(posedge clk)
      rst |=> !(cpu_stall || cpu_reset || start_cpu))
      else $error("cpu pulse while reset applied");

endmodule

bind tcm tcm_sva sva_i (
   .clk(clk), .rst(rst), .out_flit(out_flit), .out_valid(out_valid),
   .out_ready(out_ready), .cpu_stall(cpu_stall), .cpu_reset(cpu_reset),
   .start_cpu(start_cpu));

`default_nettype wire

// ==== verilog.f ====
dbg_pkg.sv
dbgnoc_rx.sv
dbg_conf_regs.sv
dbg_perf_counters.sv
dbgnoc_tx.sv
tcm.sv
tcm_sva.sv
tb_tcm.sv
